// ==== hw/cam_cfg_pkg.sv ====
// Camera configuration package
// Shared widths, SCCB constants and state encodings for the OV5640-style
// sensor bring-up logic.

`default_nettype none

package cam_cfg_pkg;

    // ------------------------------------------------------------------
    // bus and table constants
    // ------------------------------------------------------------------
    localparam logic [7:0] SCCB_WR_ID  = 8'h78;   // device write id
    localparam int         NUM_ENTRIES = 16;
    localparam int         IDX_W       = $clog2(NUM_ENTRIES);

    typedef logic [15:0]      reg_addr_t;
    typedef logic [7:0]       reg_val_t;
    typedef logic [IDX_W-1:0] entry_idx_t;

    // counter width that never collapses to zero bits
    function automatic int cnt_width(input int n);
        return (n > 1) ? $clog2(n) : 1;
    endfunction

    // ------------------------------------------------------------------
    // state encodings
    // ------------------------------------------------------------------
    typedef enum logic [2:0] {
        FETCH,
        REQ,
        WAIT_ACK,
        WAIT_RELEASE,
        DONE
    } seq_state_e;

    typedef enum logic [2:0] {
        IDLE,
        START,
        SHIFT,
        STOP,
        ACK_HOLD
    } sccb_state_e;

endpackage

`default_nettype wire

// ==== hw/cam_reg_rom.sv ====
// Sensor register table
// Returns the register address and value of one configuration entry.
// Order follows the bring-up flow: soft reset, PLL, format, window,
// output size, then stream enable.

`timescale 1ns/1ps
`default_nettype none

module cam_reg_rom
    import cam_cfg_pkg::*;
(
    input  wire entry_idx_t entry_idx,
    output reg_addr_t       reg_addr,
    output reg_val_t        reg_val
);

    always_comb begin
        case (entry_idx)
            4'd0:    begin reg_addr = 16'h3103; reg_val = 8'h11; end  // clock from pad
            4'd1:    begin reg_addr = 16'h3008; reg_val = 8'h82; end  // soft reset
            4'd2:    begin reg_addr = 16'h3008; reg_val = 8'h42; end  // power down
            4'd3:    begin reg_addr = 16'h3103; reg_val = 8'h03; end  // clock from pll
            4'd4:    begin reg_addr = 16'h3034; reg_val = 8'h1a; end
            4'd5:    begin reg_addr = 16'h3037; reg_val = 8'h13; end  // pll pre-divider
            4'd6:    begin reg_addr = 16'h3108; reg_val = 8'h01; end  // root dividers
            4'd7:    begin reg_addr = 16'h4300; reg_val = 8'h61; end  // format control
            4'd8:    begin reg_addr = 16'h501f; reg_val = 8'h01; end
            4'd9:    begin reg_addr = 16'h3800; reg_val = 8'h00; end  // window h start
            4'd10:   begin reg_addr = 16'h3804; reg_val = 8'h0a; end  // window h end
            4'd11:   begin reg_addr = 16'h3808; reg_val = 8'h04; end  // dvp width, 1024
            4'd12:   begin reg_addr = 16'h3809; reg_val = 8'h00; end
            4'd13:   begin reg_addr = 16'h380a; reg_val = 8'h02; end  // dvp height, 720
            4'd14:   begin reg_addr = 16'h380b; reg_val = 8'hd0; end
            4'd15:   begin reg_addr = 16'h3008; reg_val = 8'h02; end  // wake up, stream on
            // chip id register is read only, so a stray write does nothing
            default: begin reg_addr = 16'h300a; reg_val = 8'h00; end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/sccb_phase_timer.sv ====
// SCCB phase timer
// Divides sysclk into one-cycle ticks, one per quarter of an SCCB bit.
// The count restarts from its reload value whenever tick_en is low.

`timescale 1ns/1ps
`default_nettype none

module sccb_phase_timer
    import cam_cfg_pkg::*;
#(
    parameter int CLK_DIV = 125
) (
    input  wire  sysclk,
    input  wire  rst_n,
    input  wire  tick_en,
    output logic tick
);

    localparam int             CNT_W  = cnt_width(CLK_DIV);
    localparam logic [CNT_W-1:0] RELOAD = CNT_W'(CLK_DIV - 1);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            cnt  <= RELOAD;
            tick <= 1'b0;
        end else if (!tick_en) begin
            cnt  <= RELOAD;      // hold while the bus is idle
            tick <= 1'b0;
        end else if (cnt == '0) begin
            cnt  <= RELOAD;
            tick <= 1'b1;
        end else begin
            cnt  <= cnt - 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== hw/sccb_write_master.sv ====
// SCCB write master
// Sends one three-phase write (device id, address high, address low,
// value) per request and answers with a four-phase req/ack handshake.
// Each bit slot spans four timer ticks; the ninth slot of every byte is
// released so the external pull-up holds the line.

`timescale 1ns/1ps
`default_nettype none

module sccb_write_master
    import cam_cfg_pkg::*;
#(
    parameter int CLK_DIV = 125
) (
    input  wire            sysclk,
    input  wire            rst_n,
    input  wire            wr_req,
    input  wire reg_addr_t reg_addr,
    input  wire reg_val_t  reg_val,
    output logic           wr_ack,
    output logic           cmos_sclk,
    output logic           cmos_sdat,
    output logic           cmos_sdat_oe
);

    localparam logic [3:0] REL_SLOT = 4'd8;   // don't-care slot after 8 data bits

    sccb_state_e state;
    logic [1:0]  phase;       // quarter of the current bit
    logic [3:0]  bit_cnt;
    logic [1:0]  byte_cnt;
    logic [31:0] shift_q;
    logic        tick_en;
    logic        tick;
    logic        capture;
    logic        slot_end;
    logic        sclk_nxt;
    logic        sdat_nxt;
    logic        oe_nxt;

    assign tick_en  = (state == START) || (state == SHIFT) || (state == STOP);
    assign capture  = (state == IDLE) && wr_req && !wr_ack;
    assign slot_end = tick && (phase == 2'd3);

    sccb_phase_timer #(
        .CLK_DIV (CLK_DIV)
    ) u_timer (
        .sysclk  (sysclk),
        .rst_n   (rst_n),
        .tick_en (tick_en),
        .tick    (tick)
    );

    // ------------------------------------------------------------------
    // frame sequencing
    // ------------------------------------------------------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            phase    <= 2'd0;
            bit_cnt  <= 4'd0;
            byte_cnt <= 2'd0;
            wr_ack   <= 1'b0;
        end else begin
            if (tick) phase <= phase + 2'd1;   // wraps to 0 at every slot end
            case (state)
                IDLE: begin
                    if (capture) state <= START;
                end
                START: begin
                    if (slot_end) begin
                        state    <= SHIFT;
                        bit_cnt  <= 4'd0;
                        byte_cnt <= 2'd0;
                    end
                end
                SHIFT: begin
                    if (slot_end) begin
                        if (bit_cnt == REL_SLOT) begin
                            bit_cnt  <= 4'd0;
                            byte_cnt <= byte_cnt + 2'd1;
                            if (byte_cnt == 2'd3) state <= STOP;
                        end else begin
                            bit_cnt <= bit_cnt + 4'd1;
                        end
                    end
                end
                STOP: begin
                    if (slot_end) begin
                        state  <= ACK_HOLD;
                        wr_ack <= 1'b1;
                    end
                end
                ACK_HOLD: begin
                    if (!wr_req) begin
                        state  <= IDLE;
                        wr_ack <= 1'b0;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // id, address and value go out msb first
    always_ff @(posedge sysclk) begin
        if (capture) begin
            shift_q <= {SCCB_WR_ID, reg_addr, reg_val};
        end else if (state == SHIFT && slot_end && bit_cnt != REL_SLOT) begin
            shift_q <= {shift_q[30:0], 1'b0};
        end
    end

    // ------------------------------------------------------------------
    // line shaping
    // ------------------------------------------------------------------
    always_comb begin
        sclk_nxt = 1'b1;      // idle bus
        sdat_nxt = 1'b1;
        oe_nxt   = 1'b1;
        case (state)
            START: begin
                sclk_nxt = (phase != 2'd3);
                sdat_nxt = (phase == 2'd0);          // falls with sclk high
            end
            SHIFT: begin
                sclk_nxt = (phase == 2'd1) || (phase == 2'd2);
                if (bit_cnt == REL_SLOT) oe_nxt = 1'b0;
                else sdat_nxt = shift_q[31];
            end
            STOP: begin
                sclk_nxt = (phase != 2'd0);
                sdat_nxt = phase[1];                 // rises with sclk high
            end
            default: ;
        endcase
    end

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            cmos_sclk    <= 1'b1;
            cmos_sdat    <= 1'b1;
            cmos_sdat_oe <= 1'b1;
        end else begin
            cmos_sclk    <= sclk_nxt;
            cmos_sdat    <= sdat_nxt;
            cmos_sdat_oe <= oe_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== hw/cam_init_seq.sv ====
// Camera init sequencer
// Walks the register table once after reset, requesting one SCCB write
// per entry over a four-phase req/ack handshake, and raises cfg_done
// once the last entry has been written.

`timescale 1ns/1ps
`default_nettype none

module cam_init_seq
    import cam_cfg_pkg::*;
(
    input  wire        sysclk,
    input  wire        rst_n,
    input  wire        wr_ack,
    output entry_idx_t entry_idx,
    output logic       wr_req,
    output logic       cfg_done
);

    localparam entry_idx_t LAST_IDX = entry_idx_t'(NUM_ENTRIES - 1);

    seq_state_e state;

    // ------------------------------------------------------------------
    // table walk
    // ------------------------------------------------------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= FETCH;
            entry_idx <= '0;
            wr_req    <= 1'b0;
            cfg_done  <= 1'b0;
        end else begin
            case (state)
                // rom output settles on the new index
                FETCH: begin
                    state <= REQ;
                end
                REQ: begin
                    wr_req <= 1'b1;
                    state  <= WAIT_ACK;
                end
                WAIT_ACK: begin
                    if (wr_ack) begin
                        wr_req <= 1'b0;
                        state  <= WAIT_RELEASE;
                    end
                end
                // handshake closes when the master drops ack
                WAIT_RELEASE: begin
                    if (!wr_ack) begin
                        if (entry_idx == LAST_IDX) begin
                            cfg_done <= 1'b1;
                            state    <= DONE;
                        end else begin
                            entry_idx <= entry_idx + 1'b1;
                            state     <= FETCH;
                        end
                    end
                end
                DONE: begin
                    state <= DONE;     // bus stays idle until reset
                end
                default: state <= FETCH;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/cam_init_top.sv ====
// Camera init top level
// Brings up an OV5640-style sensor over SCCB: a sequencer walks the
// register table and a write master puts each entry on the bus.
// CLK_DIV sets the quarter-bit period in sysclk cycles.

`timescale 1ns/1ps
`default_nettype none

module cam_init_top
    import cam_cfg_pkg::*;
#(
    parameter int CLK_DIV = 125        // about 100 kHz sclk at 50 MHz
) (
    input  wire  sysclk,
    input  wire  rst_n,
    output logic cmos_sclk,
    output logic cmos_sdat,
    output logic cmos_sdat_oe,
    output logic cfg_done
);

    entry_idx_t entry_idx;
    reg_addr_t  reg_addr;
    reg_val_t   reg_val;
    logic       wr_req;
    logic       wr_ack;

    cam_init_seq u_seq (
        .sysclk    (sysclk),
        .rst_n     (rst_n),
        .wr_ack    (wr_ack),
        .entry_idx (entry_idx),
        .wr_req    (wr_req),
        .cfg_done  (cfg_done)
    );

    cam_reg_rom u_rom (
        .entry_idx (entry_idx),
        .reg_addr  (reg_addr),
        .reg_val   (reg_val)
    );

    sccb_write_master #(
        .CLK_DIV (CLK_DIV)
    ) u_master (
        .sysclk       (sysclk),
        .rst_n        (rst_n),
        .wr_req       (wr_req),
        .reg_addr     (reg_addr),
        .reg_val      (reg_val),
        .wr_ack       (wr_ack),
        .cmos_sclk    (cmos_sclk),
        .cmos_sdat    (cmos_sdat),
        .cmos_sdat_oe (cmos_sdat_oe)
    );

endmodule

`default_nettype wire

// ==== dv/cam_init_assertions.sv ====
// SCCB bus and handshake assertions
// Bound into the write master: req/ack ordering, stable request data
// and the SCCB rule that data only moves while sclk is low.

`timescale 1ns/1ps
`default_nettype none

module cam_init_assertions
    import cam_cfg_pkg::*;
(
    input wire              sysclk,
    input wire              rst_n,
    input wire              wr_req,
    input wire              wr_ack,
    input wire reg_addr_t   reg_addr,
    input wire reg_val_t    reg_val,
    input wire              cmos_sclk,
    input wire              cmos_sdat,
    input wire sccb_state_e bus_state
);

    // ack only answers a pending request
    ack_needs_req: assert property (@(posedge sysclk) disable iff (!rst_n)
        $rose(wr_ack) |-> wr_req)
        else $error("wr_ack rose while wr_req was low");

    req_held_until_ack: assert property (@(posedge sysclk) disable iff (!rst_n)
        wr_req && !wr_ack |=> wr_req)
        else $error("wr_req dropped before wr_ack");

    req_data_stable: assert property (@(posedge sysclk) disable iff (!rst_n)
        wr_req && !wr_ack |=> $stable(reg_addr) && $stable(reg_val))
        else $error("register address or value moved during a request");

    // start and stop are the only edges with sclk high
    sdat_moves_low: assert property (@(posedge sysclk) disable iff (!rst_n)
        $changed(cmos_sdat) && cmos_sclk && $past(cmos_sclk)
            |-> (bus_state == START) || (bus_state == STOP))
        else $error("cmos_sdat changed while cmos_sclk was high");

endmodule

bind sccb_write_master cam_init_assertions u_assert (
    .sysclk    (sysclk),
    .rst_n     (rst_n),
    .wr_req    (wr_req),
    .wr_ack    (wr_ack),
    .reg_addr  (reg_addr),
    .reg_val   (reg_val),
    .cmos_sclk (cmos_sclk),
    .cmos_sdat (cmos_sdat),
    .bus_state (state)
);

`default_nettype wire

// ==== dv/cam_init_tb.sv ====
// Camera init testbench
// Decodes every SCCB write frame off the bus and compares it with the
// expected register table. Runs the table after power-on, cuts a second
// pass short with a reset inside entry 5, and expects a full restart.

`timescale 1ns/1ps
`default_nettype none

module cam_init_tb
    import cam_cfg_pkg::*;
();

    localparam int         CLK_DIV      = 4;
    localparam logic [7:0] WRITE_ID     = 8'h78;
    localparam int         RESET_CYCLES = 10;
    localparam int         GAP_TIMEOUT  = 1000;   // between frames
    localparam int         EDGE_TIMEOUT = 64;     // one bit is 16 cycles
    localparam int         DONE_TIMEOUT = 200;
    localparam int         IDLE_CYCLES  = 2000;
    localparam int         CUT_ENTRY    = 5;

    // expected {address, value} writes in bring-up order
    localparam logic [23:0] EXP_TABLE [NUM_ENTRIES] = '{
        24'h3103_11, 24'h3008_82, 24'h3008_42, 24'h3103_03,
        24'h3034_1a, 24'h3037_13, 24'h3108_01, 24'h4300_61,
        24'h501f_01, 24'h3800_00, 24'h3804_0a, 24'h3808_04,
        24'h3809_00, 24'h380a_02, 24'h380b_d0, 24'h3008_02
    };

    logic sysclk;
    logic rst_n;
    wire  cmos_sclk;
    wire  cmos_sdat;
    wire  cmos_sdat_oe;
    wire  cfg_done;
    wire  sda_line;

    logic cur_sclk;
    logic cur_sda;
    logic cur_oe;
    logic prev_sclk;
    logic prev_sda;

    cam_init_top #(
        .CLK_DIV (CLK_DIV)
    ) u_dut (
        .sysclk       (sysclk),
        .rst_n        (rst_n),
        .cmos_sclk    (cmos_sclk),
        .cmos_sdat    (cmos_sdat),
        .cmos_sdat_oe (cmos_sdat_oe),
        .cfg_done     (cfg_done)
    );

    assign sda_line = cmos_sdat_oe ? cmos_sdat : 1'b1;   // board pull-up

    always #10 sysclk = ~sysclk;

    // ------------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------------
    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_addr(input string name, input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp)
            report_failure($sformatf("MISMATCH %s expected 0x%04h actual 0x%04h",
                                     name, exp, act));
    endtask

    task automatic check_val(input string name, input reg_val_t exp, input reg_val_t act);
        if (act !== exp)
            report_failure($sformatf("MISMATCH %s expected 0x%02h actual 0x%02h",
                                     name, exp, act));
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp)
            report_failure($sformatf("MISMATCH %s expected 0x%02h actual 0x%02h",
                                     name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
            report_failure($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
    endtask

    // ------------------------------------------------------------------
    // bus monitor
    // ------------------------------------------------------------------
    // outputs move on the rising edge, so look at them on the falling one
    task automatic sample_bus();
        @(negedge sysclk);
        prev_sclk = cur_sclk;
        prev_sda  = cur_sda;
        cur_sclk  = cmos_sclk;
        cur_sda   = sda_line;
        cur_oe    = cmos_sdat_oe;
    endtask

    task automatic wait_start(input string tag);
        int n;
        bit seen;
        seen = 1'b0;
        for (n = 0; n < GAP_TIMEOUT && !seen; n++) begin
            sample_bus();
            seen = prev_sclk && cur_sclk && prev_sda && !cur_sda;
        end
        if (!seen)
            report_failure({"timeout waiting for the start condition of ", tag});
    endtask

    task automatic wait_sclk_rise(input string tag);
        int n;
        bit seen;
        seen = 1'b0;
        for (n = 0; n < EDGE_TIMEOUT && !seen; n++) begin
            sample_bus();
            seen = !prev_sclk && cur_sclk;
        end
        if (!seen)
            report_failure({"timeout waiting for a rising sclk edge in ", tag});
    endtask

    task automatic wait_stop(input string tag);
        int n;
        bit seen;
        wait_sclk_rise(tag);
        check_bit({tag, " data low before stop"}, 1'b0, cur_sda);
        seen = 1'b0;
        for (n = 0; n < EDGE_TIMEOUT && !seen; n++) begin
            sample_bus();
            if (!cur_sclk)
                report_failure({"sclk fell before the stop condition of ", tag});
            seen = !prev_sda && cur_sda;
        end
        if (!seen)
            report_failure({"timeout waiting for the stop condition of ", tag});
    endtask

    // start, 36 slots, stop; slot 8 of each byte is released
    task automatic check_frame(input int idx);
        string       tag;
        logic [31:0] word;
        int          slot;
        tag  = $sformatf("entry %0d", idx);
        word = '0;
        wait_start(tag);
        check_bit({tag, " cfg_done during frame"}, 1'b0, cfg_done);
        for (slot = 0; slot < 36; slot++) begin
            wait_sclk_rise(tag);
            if (slot % 9 == 8) begin
                check_bit({tag, " released slot oe"}, 1'b0, cur_oe);
            end else begin
                check_bit({tag, " data slot oe"}, 1'b1, cur_oe);
                word = {word[30:0], cur_sda};
            end
        end
        wait_stop(tag);
        check_byte({tag, " id"}, WRITE_ID, word[31:24]);
        check_addr({tag, " addr"}, EXP_TABLE[idx][23:8], word[23:8]);
        check_val({tag, " value"}, EXP_TABLE[idx][7:0], word[7:0]);
    endtask

    // ------------------------------------------------------------------
    // sequences
    // ------------------------------------------------------------------
    task automatic apply_reset(input string tag);
        int i;
        @(posedge sysclk);
        rst_n <= 1'b0;
        for (i = 0; i < RESET_CYCLES; i++) begin
            sample_bus();
            check_bit({tag, " cfg_done in reset"}, 1'b0, cfg_done);
            check_bit({tag, " sclk in reset"}, 1'b1, cur_sclk);
            check_bit({tag, " line in reset"}, 1'b1, cur_sda);
            check_bit({tag, " oe in reset"}, 1'b1, cur_oe);
        end
        @(posedge sysclk);
        rst_n <= 1'b1;
        sample_bus();
        check_bit({tag, " cfg_done after reset"}, 1'b0, cfg_done);
        check_bit({tag, " sclk after reset"}, 1'b1, cur_sclk);
        check_bit({tag, " line after reset"}, 1'b1, cur_sda);
        check_bit({tag, " oe after reset"}, 1'b1, cur_oe);
    endtask

    task automatic check_completion(input string tag);
        int n;
        bit seen;
        seen = 1'b0;
        for (n = 0; n < DONE_TIMEOUT && !seen; n++) begin
            sample_bus();
            seen = cfg_done;
        end
        if (!seen)
            report_failure({"timeout waiting for cfg_done in ", tag});
        // a seventeenth frame would show up here as a start
        for (n = 0; n < IDLE_CYCLES; n++) begin
            sample_bus();
            if (prev_sclk && cur_sclk && prev_sda && !cur_sda)
                report_failure({"start condition after cfg_done in ", tag});
            check_bit({tag, " cfg_done held"}, 1'b1, cfg_done);
            check_bit({tag, " idle sclk"}, 1'b1, cur_sclk);
            check_bit({tag, " idle line"}, 1'b1, cur_sda);
        end
    endtask

    task automatic run_table(input string tag);
        int i;
        for (i = 0; i < NUM_ENTRIES; i++)
            check_frame(i);
        check_completion(tag);
    endtask

    initial begin
        int i;
        sysclk    = 1'b0;
        rst_n    <= 1'b0;
        cur_sclk  = 1'b1;
        cur_sda   = 1'b1;
        cur_oe    = 1'b1;
        prev_sclk = 1'b1;
        prev_sda  = 1'b1;

        apply_reset("power-on reset");
        run_table("first pass");

        // second pass is cut short inside entry 5
        apply_reset("second reset");
        for (i = 0; i < CUT_ENTRY; i++)
            check_frame(i);
        wait_start("entry 5");
        for (i = 0; i < 12; i++)
            wait_sclk_rise("entry 5");
        apply_reset("mid-run reset");
        run_table("pass after mid-run reset");

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
hw/cam_cfg_pkg.sv
hw/cam_reg_rom.sv
hw/sccb_phase_timer.sv
hw/sccb_write_master.sv
hw/cam_init_seq.sv
hw/cam_init_top.sv
dv/cam_init_assertions.sv
dv/cam_init_tb.sv

// ==== Makefile ====
# Verilator flow for the SCCB camera init project
#   make        build and run the testbench
#   make lint   lint the design
#   make clean  remove build output

VERILATOR  ?= verilator
TB_TOP     ?= cam_init_tb
RTL_TOP    ?= cam_init_top
FLIST      ?= list.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
FAIL_MSG   ?= Done: errors found
PASS_MSG   ?= Done: no errors

SRCS := $(shell grep -v '^+' $(FLIST))
SIM  := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "FAILED, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "FAILED, run ended early, see $(LOG)"; exit 1; \
	fi
	@echo "PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
